/* include/core_consts.svh */
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// data path width
`define XLEN 32

// architectural integer registers
`define NUM_REGS 32

// data memory depth in words, indexed by address bits [7:2]
`define DMEM_WORDS 64

`endif

/* design/rv32i_isa_pkg.sv */
`default_nettype none

package rv32i_isa_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    // funct3 of loads and stores
    typedef enum logic [2:0] {
        mem_byte   = 3'b000,
        mem_half   = 3'b001,
        mem_word   = 3'b010,
        mem_byte_u = 3'b100,
        mem_half_u = 3'b101
    } mem_width_e;

endpackage

`default_nettype wire

/* design/rv32i_ctrl_pkg.sv */
`default_nettype none

package rv32i_ctrl_pkg;

    // source of the register write value
    typedef enum logic [2:0] {
        rf_alu_out  = 3'b000,
        rf_u_imm    = 3'b001,
        rf_pc_plus4 = 3'b010,
        rf_load     = 3'b011
    } regfilemux_sel_e;

endpackage

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module regfile (
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire  [$clog2(`NUM_REGS)-1:0]  rs1_addr_i,
    input  wire  [$clog2(`NUM_REGS)-1:0]  rs2_addr_i,
    output logic [`XLEN-1:0]              rs1_data_o,
    output logic [`XLEN-1:0]              rs2_data_o,
    input  wire                           we_i,
    input  wire  [$clog2(`NUM_REGS)-1:0]  waddr_i,
    input  wire  [`XLEN-1:0]              wdata_i
);

    logic [`XLEN-1:0] regs [`NUM_REGS];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // x0 hardwired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

`default_nettype wire

/* design/data_mem.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module data_mem (
    input  wire                            clk,
    input  wire  [$clog2(`DMEM_WORDS)-1:0] addr_i,
    input  wire  [`XLEN-1:0]               wdata_i,
    input  wire  [3:0]                     be_i,
    input  wire                            we_i,
    output logic [`XLEN-1:0]               rdata_o
);

    logic [`XLEN-1:0] mem [`DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
        // old data on a same-word write
        rdata_o <= mem[addr_i];
    end

endmodule

`default_nettype wire

/* design/decode.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module decode
    import rv32i_isa_pkg::*, rv32i_ctrl_pkg::*;
(
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire                           instr_valid_i,
    input  wire  [31:0]                   instr_i,
    input  wire  [`XLEN-1:0]              pc_i,
    output logic                          instr_ready_o,
    output logic [$clog2(`NUM_REGS)-1:0]  rs1_addr_o,
    output logic [$clog2(`NUM_REGS)-1:0]  rs2_addr_o,
    input  wire  [`XLEN-1:0]              rs1_data_i,
    input  wire  [`XLEN-1:0]              rs2_data_i,
    input  wire                           ex_fwd_valid_i,
    input  wire  [$clog2(`NUM_REGS)-1:0]  ex_fwd_rd_i,
    input  wire  [`XLEN-1:0]              ex_fwd_data_i,
    input  wire                           ex_is_load_i,
    input  wire                           wb_fwd_valid_i,
    input  wire  [$clog2(`NUM_REGS)-1:0]  wb_fwd_rd_i,
    input  wire  [`XLEN-1:0]              wb_fwd_data_i,
    output logic                          id_valid_o,
    output alu_op_e                       id_alu_op_o,
    output logic [`XLEN-1:0]              id_op_a_o,
    output logic [`XLEN-1:0]              id_op_b_o,
    output logic [`XLEN-1:0]              id_store_data_o,
    output logic [$clog2(`NUM_REGS)-1:0]  id_rd_o,
    output mem_width_e                    id_mem_width_o,
    output logic                          id_mem_read_o,
    output logic                          id_mem_write_o,
    output regfilemux_sel_e               id_regfilemux_sel_o,
    output logic [`XLEN-1:0]              id_u_imm_o,
    output logic [`XLEN-1:0]              id_pc_o
);

    opcode_e         opcode;
    logic [`XLEN-1:0] i_imm, s_imm, u_imm;
    logic [`XLEN-1:0] rs1_val, rs2_val, op_b;
    logic            use_pc, uses_rs1, uses_rs2, writes_rd, legal;
    logic            mem_read, mem_write, stall, accept;
    alu_op_e         alu_op;
    regfilemux_sel_e rf_sel;

    function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic f7b5,
                                       input logic is_reg);
        case (f3)
            3'b000:  return (is_reg && f7b5) ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return f7b5 ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // newest result wins: execute, then writeback, then the file
    function automatic logic [`XLEN-1:0] fwd(input logic [$clog2(`NUM_REGS)-1:0] addr,
                                             input logic [`XLEN-1:0] file_val);
        if (addr != '0 && ex_fwd_valid_i && ex_fwd_rd_i == addr)
            return ex_fwd_data_i;
        else if (addr != '0 && wb_fwd_valid_i && wb_fwd_rd_i == addr)
            return wb_fwd_data_i;
        return file_val;
    endfunction

    assign opcode     = opcode_e'(instr_i[6:0]);
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign u_imm = {instr_i[31:12], 12'b0};

    always_comb begin
        rs1_val = fwd(rs1_addr_o, rs1_data_i);
        rs2_val = fwd(rs2_addr_o, rs2_data_i);
    end

    always_comb begin
        alu_op    = alu_add;
        op_b      = i_imm;
        use_pc    = 1'b0;
        uses_rs1  = 1'b1;
        uses_rs2  = 1'b0;
        writes_rd = 1'b1;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        rf_sel    = rf_alu_out;
        legal     = 1'b1;
        case (opcode)
            opc_op: begin
                alu_op   = alu_fn(instr_i[14:12], instr_i[30], 1'b1);
                op_b     = rs2_val;
                uses_rs2 = 1'b1;
            end
            opc_op_imm: alu_op = alu_fn(instr_i[14:12], instr_i[30], 1'b0);
            opc_lui: begin
                alu_op   = alu_pass_b;
                op_b     = u_imm;
                uses_rs1 = 1'b0;
                rf_sel   = rf_u_imm;
            end
            opc_auipc: begin
                use_pc   = 1'b1;
                op_b     = u_imm;
                uses_rs1 = 1'b0;
            end
            // link only, the ALU forms pc + 4 so execute can forward it
            opc_jal, opc_jalr: begin
                use_pc   = 1'b1;
                op_b     = `XLEN'(4);
                uses_rs1 = (opcode == opc_jalr);
                rf_sel   = rf_pc_plus4;
            end
            opc_load: begin
                mem_read = 1'b1;
                rf_sel   = rf_load;
            end
            opc_store: begin
                op_b      = s_imm;
                uses_rs2  = 1'b1;
                writes_rd = 1'b0;
                mem_write = 1'b1;
            end
            default: begin
                legal     = 1'b0;
                writes_rd = 1'b0;
            end
        endcase
    end

    // load in execute whose data is not back yet
    assign stall = ex_is_load_i && ex_fwd_rd_i != '0 &&
                   ((uses_rs1 && rs1_addr_o == ex_fwd_rd_i) ||
                    (uses_rs2 && rs2_addr_o == ex_fwd_rd_i));

    assign instr_ready_o = !stall;
    assign accept        = instr_valid_i && instr_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_valid_o <= 1'b0;
        end else begin
            id_valid_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            id_alu_op_o         <= alu_op;
            id_op_a_o           <= use_pc ? pc_i : rs1_val;
            id_op_b_o           <= op_b;
            id_store_data_o     <= rs2_val;
            id_rd_o             <= writes_rd ? instr_i[11:7] : '0;
            id_mem_width_o      <= mem_width_e'(instr_i[14:12]);
            id_mem_read_o       <= mem_read;
            id_mem_write_o      <= mem_write;
            id_regfilemux_sel_o <= rf_sel;
            id_u_imm_o          <= u_imm;
            id_pc_o             <= pc_i;
        end
    end

    a_known_opcode: assert property (@(posedge clk) disable iff (!arst_n_i)
        accept |-> legal)
        else $error("decode accepted unknown opcode %h", instr_i[6:0]);

endmodule

`default_nettype wire

/* design/execute.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module execute
    import rv32i_isa_pkg::*, rv32i_ctrl_pkg::*;
(
    input  wire                            clk,
    input  wire                            arst_n_i,
    input  wire                            id_valid_i,
    input  alu_op_e                        id_alu_op_i,
    input  wire  [`XLEN-1:0]               id_op_a_i,
    input  wire  [`XLEN-1:0]               id_op_b_i,
    input  wire  [`XLEN-1:0]               id_store_data_i,
    input  wire  [$clog2(`NUM_REGS)-1:0]   id_rd_i,
    input  mem_width_e                     id_mem_width_i,
    input  wire                            id_mem_read_i,
    input  wire                            id_mem_write_i,
    input  regfilemux_sel_e                id_regfilemux_sel_i,
    input  wire  [`XLEN-1:0]               id_u_imm_i,
    input  wire  [`XLEN-1:0]               id_pc_i,
    output logic                           ex_fwd_valid_o,
    output logic [$clog2(`NUM_REGS)-1:0]   ex_fwd_rd_o,
    output logic [`XLEN-1:0]               ex_fwd_data_o,
    output logic                           ex_is_load_o,
    output logic [$clog2(`DMEM_WORDS)-1:0] mem_addr_o,
    output logic [`XLEN-1:0]               mem_wdata_o,
    output logic [3:0]                     mem_be_o,
    output logic                           mem_we_o,
    output logic                           ex_valid_o,
    output logic [$clog2(`NUM_REGS)-1:0]   ex_rd_o,
    output logic [`XLEN-1:0]               ex_alu_out_o,
    output logic [`XLEN-1:0]               ex_u_imm_o,
    output logic [`XLEN-1:0]               ex_pc_o,
    output mem_width_e                     ex_mem_width_o,
    output regfilemux_sel_e                ex_regfilemux_sel_o,
    output logic [1:0]                     ex_offset_o
);

    localparam int MA = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] alu_res;
    logic [1:0]       offset;

    always_comb begin
        case (id_alu_op_i)
            alu_sub:    alu_res = id_op_a_i - id_op_b_i;
            alu_sll:    alu_res = id_op_a_i << id_op_b_i[4:0];
            alu_slt:    alu_res = `XLEN'($signed(id_op_a_i) < $signed(id_op_b_i));
            alu_sltu:   alu_res = `XLEN'(id_op_a_i < id_op_b_i);
            alu_xor:    alu_res = id_op_a_i ^ id_op_b_i;
            alu_srl:    alu_res = id_op_a_i >> id_op_b_i[4:0];
            alu_sra:    alu_res = $unsigned($signed(id_op_a_i) >>> id_op_b_i[4:0]);
            alu_or:     alu_res = id_op_a_i | id_op_b_i;
            alu_and:    alu_res = id_op_a_i & id_op_b_i;
            alu_pass_b: alu_res = id_op_b_i;
            default:    alu_res = id_op_a_i + id_op_b_i;
        endcase
    end

    // loads forward nothing useful here, decode stalls on them instead
    assign ex_fwd_valid_o = id_valid_i && id_rd_i != '0;
    assign ex_fwd_rd_o    = id_rd_i;
    assign ex_fwd_data_o  = alu_res;
    assign ex_is_load_o   = id_valid_i && id_mem_read_i;

    assign offset     = alu_res[1:0];
    assign mem_addr_o = alu_res[MA+1:2];
    assign mem_we_o   = id_valid_i && id_mem_write_i;

    // store data replicated into every lane, the enable picks the lanes
    always_comb begin
        case (id_mem_width_i)
            mem_byte: begin
                mem_wdata_o = {4{id_store_data_i[7:0]}};
                mem_be_o    = 4'b0001 << offset;
            end
            mem_half: begin
                mem_wdata_o = {2{id_store_data_i[15:0]}};
                mem_be_o    = 4'b0011 << offset;
            end
            default: begin
                mem_wdata_o = id_store_data_i;
                mem_be_o    = 4'b1111;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= id_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        ex_rd_o             <= id_rd_i;
        ex_alu_out_o        <= alu_res;
        ex_u_imm_o          <= id_u_imm_i;
        ex_pc_o             <= id_pc_i;
        ex_mem_width_o      <= id_mem_width_i;
        ex_regfilemux_sel_o <= id_regfilemux_sel_i;
        ex_offset_o         <= offset;
    end

    a_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        id_valid_i && (id_mem_read_i || id_mem_write_i) |->
            (id_mem_width_i inside {mem_half, mem_half_u} -> !offset[0]) &&
            (id_mem_width_i == mem_word -> offset == 2'b00))
        else $error("misaligned access at %h", alu_res);

endmodule

`default_nettype wire

/* design/writeback.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module writeback
    import rv32i_isa_pkg::*, rv32i_ctrl_pkg::*;
(
    input  wire                           ex_valid_i,
    input  wire  [$clog2(`NUM_REGS)-1:0]  ex_rd_i,
    input  wire  [`XLEN-1:0]              ex_alu_out_i,
    input  wire  [`XLEN-1:0]              ex_u_imm_i,
    input  wire  [`XLEN-1:0]              ex_pc_i,
    input  mem_width_e                    ex_mem_width_i,
    input  regfilemux_sel_e               ex_regfilemux_sel_i,
    input  wire  [1:0]                    ex_offset_i,
    input  wire  [`XLEN-1:0]              mem_rdata_i,
    output logic                          rf_we_o,
    output logic [$clog2(`NUM_REGS)-1:0]  rf_waddr_o,
    output logic [`XLEN-1:0]              rf_wdata_o,
    output logic                          wb_valid_o,
    output logic [$clog2(`NUM_REGS)-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]              wb_data_o
);

    logic [7:0]       load_byte;
    logic [15:0]      load_half;
    logic [`XLEN-1:0] load_val;
    logic [`XLEN-1:0] regfilemux_out;

    assign load_byte = mem_rdata_i[8*ex_offset_i +: 8];
    assign load_half = ex_offset_i[1] ? mem_rdata_i[31:16] : mem_rdata_i[15:0];

    always_comb begin
        case (ex_mem_width_i)
            mem_byte:   load_val = {{24{load_byte[7]}}, load_byte};
            mem_byte_u: load_val = {24'h0, load_byte};
            mem_half:   load_val = {{16{load_half[15]}}, load_half};
            mem_half_u: load_val = {16'h0, load_half};
            default:    load_val = mem_rdata_i;
        endcase
    end

    always_comb begin
        case (ex_regfilemux_sel_i)
            rf_u_imm:    regfilemux_out = ex_u_imm_i;
            rf_pc_plus4: regfilemux_out = ex_pc_i + `XLEN'(4);
            rf_load:     regfilemux_out = load_val;
            default:     regfilemux_out = ex_alu_out_i;
        endcase
    end

    // stores and x0 targets arrive with rd zero
    assign rf_we_o    = ex_valid_i && ex_rd_i != '0;
    assign rf_waddr_o = ex_rd_i;
    assign rf_wdata_o = regfilemux_out;

    assign wb_valid_o = rf_we_o;
    assign wb_rd_o    = ex_rd_i;
    assign wb_data_o  = regfilemux_out;

endmodule

`default_nettype wire

/* design/core_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module core_top
    import rv32i_isa_pkg::*, rv32i_ctrl_pkg::*;
(
    input  wire                           clk,
    input  wire                           arst_n_i,
    input  wire                           instr_valid_i,
    input  wire  [31:0]                   instr_i,
    input  wire  [`XLEN-1:0]              pc_i,
    output logic                          instr_ready_o,
    output logic                          wb_valid_o,
    output logic [$clog2(`NUM_REGS)-1:0]  wb_rd_o,
    output logic [`XLEN-1:0]              wb_data_o
);

    logic [$clog2(`NUM_REGS)-1:0]   rs1_addr, rs2_addr, rf_waddr;
    logic [`XLEN-1:0]               rs1_data, rs2_data, rf_wdata;
    logic                           rf_we;
    logic                           ex_fwd_valid, ex_is_load;
    logic [$clog2(`NUM_REGS)-1:0]   ex_fwd_rd;
    logic [`XLEN-1:0]               ex_fwd_data;
    logic [$clog2(`DMEM_WORDS)-1:0] mem_addr;
    logic [`XLEN-1:0]               mem_wdata, mem_rdata;
    logic [3:0]                     mem_be;
    logic                           mem_we;

    // ID/EX
    logic                           id_valid, id_mem_read, id_mem_write;
    alu_op_e                        id_alu_op;
    logic [`XLEN-1:0]               id_op_a, id_op_b, id_store_data, id_u_imm, id_pc;
    logic [$clog2(`NUM_REGS)-1:0]   id_rd;
    mem_width_e                     id_mem_width;
    regfilemux_sel_e                id_regfilemux_sel;

    // EX/WB
    logic                           ex_valid;
    logic [$clog2(`NUM_REGS)-1:0]   ex_rd;
    logic [`XLEN-1:0]               ex_alu_out, ex_u_imm, ex_pc;
    mem_width_e                     ex_mem_width;
    regfilemux_sel_e                ex_regfilemux_sel;
    logic [1:0]                     ex_offset;

    decode u_decode (
        .clk, .arst_n_i, .instr_valid_i, .instr_i, .pc_i, .instr_ready_o,
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .ex_fwd_valid_i(ex_fwd_valid), .ex_fwd_rd_i(ex_fwd_rd),
        .ex_fwd_data_i(ex_fwd_data), .ex_is_load_i(ex_is_load),
        .wb_fwd_valid_i(wb_valid_o), .wb_fwd_rd_i(wb_rd_o), .wb_fwd_data_i(wb_data_o),
        .id_valid_o(id_valid), .id_alu_op_o(id_alu_op), .id_op_a_o(id_op_a),
        .id_op_b_o(id_op_b), .id_store_data_o(id_store_data), .id_rd_o(id_rd),
        .id_mem_width_o(id_mem_width), .id_mem_read_o(id_mem_read),
        .id_mem_write_o(id_mem_write), .id_regfilemux_sel_o(id_regfilemux_sel),
        .id_u_imm_o(id_u_imm), .id_pc_o(id_pc)
    );

    execute u_execute (
        .clk, .arst_n_i,
        .id_valid_i(id_valid), .id_alu_op_i(id_alu_op), .id_op_a_i(id_op_a),
        .id_op_b_i(id_op_b), .id_store_data_i(id_store_data), .id_rd_i(id_rd),
        .id_mem_width_i(id_mem_width), .id_mem_read_i(id_mem_read),
        .id_mem_write_i(id_mem_write), .id_regfilemux_sel_i(id_regfilemux_sel),
        .id_u_imm_i(id_u_imm), .id_pc_i(id_pc),
        .ex_fwd_valid_o(ex_fwd_valid), .ex_fwd_rd_o(ex_fwd_rd),
        .ex_fwd_data_o(ex_fwd_data), .ex_is_load_o(ex_is_load),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata), .mem_be_o(mem_be),
        .mem_we_o(mem_we),
        .ex_valid_o(ex_valid), .ex_rd_o(ex_rd), .ex_alu_out_o(ex_alu_out),
        .ex_u_imm_o(ex_u_imm), .ex_pc_o(ex_pc), .ex_mem_width_o(ex_mem_width),
        .ex_regfilemux_sel_o(ex_regfilemux_sel), .ex_offset_o(ex_offset)
    );

    writeback u_writeback (
        .ex_valid_i(ex_valid), .ex_rd_i(ex_rd), .ex_alu_out_i(ex_alu_out),
        .ex_u_imm_i(ex_u_imm), .ex_pc_i(ex_pc), .ex_mem_width_i(ex_mem_width),
        .ex_regfilemux_sel_i(ex_regfilemux_sel), .ex_offset_i(ex_offset),
        .mem_rdata_i(mem_rdata),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .wb_valid_o, .wb_rd_o, .wb_data_o
    );

    regfile u_regfile (
        .clk, .arst_n_i,
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
        .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
    );

    data_mem u_data_mem (
        .clk,
        .addr_i(mem_addr), .wdata_i(mem_wdata), .be_i(mem_be), .we_i(mem_we),
        .rdata_o(mem_rdata)
    );

endmodule

`default_nettype wire

/* dv/core_model.svh */
// reference ISS, runs each instruction at acceptance

localparam int MEM_AW = $clog2(`DMEM_WORDS);

logic [`XLEN-1:0] ref_regs [`NUM_REGS];
logic [`XLEN-1:0] ref_mem [`DMEM_WORDS];

// {rd, value} of register writes still to retire, oldest first
logic [36:0] expected_q [$];

task automatic clear_ref_state();
    for (int i = 0; i < `NUM_REGS; i++) begin
        ref_regs[i] = '0;
    end
    expected_q.delete();
endtask

function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// byte or halfword at the offset, then sign or zero fill
function automatic logic [31:0] extend_load(input logic [2:0] f3, input logic [31:0] word,
                                            input logic [1:0] off);
    logic [31:0] shifted;
    shifted = word >> (8 * off);
    case (f3)
        3'b000:  return {{24{shifted[7]}}, shifted[7:0]};
        3'b100:  return {24'b0, shifted[7:0]};
        3'b001:  return {{16{shifted[15]}}, shifted[15:0]};
        3'b101:  return {16'b0, shifted[15:0]};
        default: return word;
    endcase
endfunction

task automatic iss_execute(input logic [31:0] instr, input logic [31:0] pc);
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [31:0] a, b, imm_i, imm_s, imm_u, addr, res;
    logic        writes;
    rd     = instr[11:7];
    f3     = instr[14:12];
    a      = ref_regs[instr[19:15]];
    b      = ref_regs[instr[24:20]];
    imm_i  = {{20{instr[31]}}, instr[31:20]};
    imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_u  = {instr[31:12], 12'b0};
    res    = '0;
    writes = 1'b1;
    case (opcode_e'(instr[6:0]))
        opc_op:     res = ref_alu(f3, instr[30], a, b);
        opc_op_imm: res = ref_alu(f3, f3 == 3'b101 && instr[30], a, imm_i);
        opc_lui:    res = imm_u;
        opc_auipc:  res = pc + imm_u;
        opc_jal, opc_jalr: res = pc + 32'd4;
        opc_load: begin
            addr = a + imm_i;
            res  = extend_load(f3, ref_mem[addr[MEM_AW+1:2]], addr[1:0]);
        end
        opc_store: begin
            writes = 1'b0;
            addr   = a + imm_s;
            case (f3)
                3'b000:  ref_mem[addr[MEM_AW+1:2]][8 * addr[1:0] +: 8] = b[7:0];
                3'b001:  ref_mem[addr[MEM_AW+1:2]][8 * addr[1:0] +: 16] = b[15:0];
                default: ref_mem[addr[MEM_AW+1:2]] = b;
            endcase
        end
        default: writes = 1'b0;
    endcase
    // x0 stays zero and never retires
    if (writes && rd != 5'd0) begin
        ref_regs[rd] = res;
        expected_q.push_back({rd, res});
    end
endtask

/* dv/tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "core_consts.svh"

module tb_core
    import rv32i_isa_pkg::*;
();

    localparam int NUM_RANDOM = 400;
    localparam int INIT_WORDS = 16;
    // x1..x31 probe, base setup, three per filled word
    localparam int NUM_PREAMBLE   = 31 + 2 + 3 * INIT_WORDS;
    localparam int NUM_INSTRS     = NUM_PREAMBLE + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = 4 * NUM_INSTRS + 50;
    localparam logic [4:0] BASE_REG = 5'd8;

    logic        clk;
    logic        arst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic        instr_ready_o;
    logic        wb_valid_o;
    logic [4:0]  wb_rd_o;
    logic [31:0] wb_data_o;
    logic [31:0] rng_state;
    logic [31:0] next_pc;
    int          cycle_count;
    int          load_cycle;
    logic [4:0]  load_rd;

    `include "core_model.svh"

    core_top u_dut (
        .clk, .arst_n_i, .instr_valid_i, .instr_i, .pc_i, .instr_ready_o,
        .wb_valid_o, .wb_rd_o, .wb_data_o
    );

    always #10 clk = ~clk;

    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("Regression failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input opcode_e opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input opcode_e opc);
        return {imm, rd, opc};
    endfunction

    // offset from the base, aligned to the access width
    function automatic logic [11:0] aligned_offset(input logic [2:0] f3, input logic [5:0] off);
        case (f3[1:0])
            2'b00:   return {6'b0, off};
            2'b01:   return {6'b0, off[5:1], 1'b0};
            default: return {6'b0, off[5:2], 2'b00};
        endcase
    endfunction

    // offered instruction reads the rd of a load that is still in execute
    function automatic logic expect_stall(input logic [31:0] instr);
        logic [4:0] rs1, rs2;
        rs1 = instr[19:15];
        rs2 = instr[24:20];
        if (cycle_count != load_cycle || load_rd == 5'd0) begin
            return 1'b0;
        end
        case (opcode_e'(instr[6:0]))
            opc_op, opc_store:              return rs1 == load_rd || rs2 == load_rd;
            opc_op_imm, opc_load, opc_jalr: return rs1 == load_rd;
            default:                        return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int unsigned kind;
        kind = xorshift32() % 12;
        r    = xorshift32();
        rd   = {2'b00, r[2:0]};
        rs1  = {2'b00, r[5:3]};
        rs2  = {2'b00, r[8:6]};
        f3   = r[11:9];
        imm  = r[23:12];
        case (kind)
            0, 1: begin
                if (f3 == 3'b001) begin
                    imm = {7'b0, imm[4:0]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, imm[10], 5'b0, imm[4:0]};
                end
                return i_type(imm, rs1, f3, rd, opc_op_imm);
            end
            2, 3: return r_type((f3 == 3'b000 || f3 == 3'b101) ? {1'b0, r[24], 5'b0} : 7'b0,
                                rs2, rs1, f3, rd, opc_op);
            4: return u_type(r[31:12], rd, opc_lui);
            5: return u_type(r[31:12], rd, opc_auipc);
            6: return u_type(r[31:12], rd, opc_jal);
            7: return i_type(imm, rs1, 3'b000, rd, opc_jalr);
            8, 9: begin
                // 3, 6 and 7 fold onto half, byte_u and half_u
                if (f3 == 3'b011 || f3[2:1] == 2'b11) begin
                    f3 = f3 - 3'd2;
                end
                return i_type(aligned_offset(f3, r[29:24]), BASE_REG, f3, rd, opc_load);
            end
            default: begin
                f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
                return s_type(aligned_offset(f3, r[29:24]), rs2, BASE_REG, f3);
            end
        endcase
    endfunction

    task automatic send_instr(input logic [31:0] instr);
        logic accepted;
        instr_valid_i = 1'b1;
        instr_i       = instr;
        pc_i          = next_pc;
        accepted      = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            assert (instr_ready_o === !expect_stall(instr))
                else stop_with_error($sformatf("[ERROR] instr_ready_o: got 0x%0h, expected 0x%0h",
                                               instr_ready_o, !expect_stall(instr)));
            accepted = instr_ready_o;
            @(posedge clk);
            #2;
        end
        iss_execute(instr, next_pc);
        // a load sits in execute during the next cycle
        load_cycle    = cycle_count;
        load_rd       = (instr[6:0] == opc_load) ? instr[11:7] : 5'd0;
        next_pc       = next_pc + 32'd4;
        instr_valid_i = 1'b0;
    endtask

    // junk on instr_i while valid is low
    task automatic idle_cycle();
        instr_valid_i = 1'b0;
        instr_i       = xorshift32();
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error($sformatf("timeout after %0d cycles, %0d retires outstanding",
                                      cycle_count, expected_q.size()));
        end
    end

    always @(negedge clk) begin : retire_check
        logic [36:0] expected;
        if (arst_n_i && wb_valid_o) begin
            if (expected_q.size() == 0) begin
                stop_with_error($sformatf("retire of x%0d with no instruction outstanding",
                                          wb_rd_o));
            end else begin
                expected = expected_q.pop_front();
                assert (wb_rd_o === expected[36:32])
                    else stop_with_error($sformatf("[ERROR] wb_rd_o: got 0x%02h, expected 0x%02h",
                                                   wb_rd_o, expected[36:32]));
                assert (wb_data_o === expected[31:0])
                    else stop_with_error($sformatf("[ERROR] wb_data_o: got 0x%08h, expected 0x%08h",
                                                   wb_data_o, expected[31:0]));
            end
        end
    end

    initial begin
        logic [31:0] fill;
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        rng_state     = 32'hb0208546;
        next_pc       = 32'h0000_1000;
        cycle_count   = 0;
        load_cycle    = -1;
        load_rd       = '0;
        clear_ref_state();
        repeat (5) @(posedge clk);
        #2;
        arst_n_i = 1'b1;
        @(negedge clk);
        assert (instr_ready_o === 1'b1)
            else stop_with_error("instr_ready_o is low after reset");
        @(posedge clk);
        #2;

        // every register reads zero before its first write, only x1 is written
        for (int r = 1; r < 32; r++) begin
            send_instr(r_type(7'b0, 5'(r), 5'(r), 3'b000, 5'd1, opc_op));
        end

        // base pointer at byte 0x40, then fill the words it reaches
        send_instr(u_type(20'h0, BASE_REG, opc_lui));
        send_instr(i_type(12'h040, BASE_REG, 3'b000, BASE_REG, opc_op_imm));
        for (int w = 0; w < INIT_WORDS; w++) begin
            fill = xorshift32();
            send_instr(u_type(fill[31:12], 5'd1, opc_lui));
            send_instr(i_type(fill[11:0], 5'd1, 3'b000, 5'd1, opc_op_imm));
            send_instr(s_type(12'(4 * w), 5'd1, BASE_REG, 3'b010));
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            if (xorshift32() % 4 == 0) begin
                idle_cycle();
            end
            send_instr(random_instr());
        end

        instr_valid_i = 1'b0;
        for (int i = 0; i < 10 && expected_q.size() != 0; i++) begin
            @(posedge clk);
        end
        // extra cycles so a stray retire still gets caught
        repeat (3) @(posedge clk);
        if (expected_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            stop_with_error($sformatf("%0d expected retires never appeared", expected_q.size()));
        end
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+include
+incdir+dv
design/rv32i_isa_pkg.sv
design/rv32i_ctrl_pkg.sv
design/regfile.sv
design/data_mem.sv
design/decode.sv
design/execute.sv
design/writeback.sv
design/core_top.sv
dv/tb_core.sv
